// File: logic/tcb_pkg.sv
// TCB shared definitions
// bus geometry, request encodings and the data word view
// used by the mode converter and the word memory

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ADR_WIDTH = 32;
  // byte lanes on the data bus
  localparam int unsigned TCB_BEN = 8;
  // address bits selecting a lane
  localparam int unsigned TCB_LOG = 3;

  //////////////////////////////////////////////////
  // request and response encodings
  //////////////////////////////////////////////////

  // transfer size, log2 of the byte count
  typedef enum logic [1:0] {
    TCB_BYTE   = 2'd0,
    TCB_HALF   = 2'd1,
    TCB_WORD   = 2'd2,
    TCB_DOUBLE = 2'd3
  } tcb_siz_t;

  // byte order of the access
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  // response status
  typedef enum logic {
    TCB_OKAY       = 1'b0,
    TCB_MISALIGNED = 1'b1
  } tcb_sts_t;

  // one data word, seen whole or as byte lanes
  typedef union packed {
    logic [TCB_BEN*8-1:0]    wrd;
    logic [TCB_BEN-1:0][7:0] byt;
  } tcb_data_t;

endpackage : tcb_pkg

// File: logic/tcb_riscv2memory.sv
// TCB RISC-V to memory mode converter
// flags misaligned requests, drops the lane bits of the address,
// builds byte enables from the size and rotates data between the
// manager's low lanes and the memory's address lanes (both endians)

module tcb_riscv2memory
  import tcb_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // manager request
  input  logic                         vld,
  output logic                         rdy,
  input  logic                         wen,
  input  logic [TCB_ADR_WIDTH-1:0]     adr,
  input  tcb_siz_t                     siz,
  input  tcb_ndn_t                     ndn,
  input  tcb_data_t                    wdt,
  // manager response
  output logic                         rsp_vld,
  output tcb_data_t                    rdt,
  output tcb_sts_t                     sts,
  // memory side
  output logic                         mem_vld,
  input  logic                         mem_rdy,
  output logic                         mem_wen,
  output logic [$clog2(MEM_DEPTH)-1:0] mem_adr,
  output logic [TCB_BEN-1:0]           mem_ben,
  output tcb_data_t                    mem_wdt,
  input  tcb_data_t                    mem_rdt
);

  // index of the last lane covered by a size
  function automatic logic [TCB_LOG-1:0] siz_last(input tcb_siz_t s);
    case (s)
      TCB_BYTE: siz_last = TCB_LOG'(0);
      TCB_HALF: siz_last = TCB_LOG'(1);
      TCB_WORD: siz_last = TCB_LOG'(3);
      default:  siz_last = TCB_LOG'(7);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // request path, purely combinational
  //////////////////////////////////////////////////

  logic [TCB_LOG-1:0] req_ofs;
  logic [TCB_LOG-1:0] req_last;
  logic               req_mal;
  logic               xfer;

  // lane offset inside the word
  assign req_ofs  = adr[TCB_LOG-1:0];
  assign req_last = siz_last(siz);

  // misaligned when any offset bit falls below the access size
  assign req_mal = |(req_ofs & req_last);

  // handshake straight through, memory alone stalls
  assign mem_vld = vld;
  assign rdy     = mem_rdy;
  assign mem_wen = wen;
  assign xfer    = vld & mem_rdy;

  // word index, lane bits masked off
  assign mem_adr = adr[TCB_LOG +: $clog2(MEM_DEPTH)];

  // enables and write data rotated into address lanes
  always_comb begin
    logic [TCB_LOG-1:0] lane;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      // position of memory lane i within the access
      lane = TCB_LOG'(i) - req_ofs;
      // misaligned requests leave memory untouched
      mem_ben[i] = !req_mal && (lane <= req_last);
      if (ndn == TCB_BIG) begin
        // most significant byte at the lowest address
        mem_wdt.byt[i] = wdt.byt[req_last - lane];
      end else begin
        mem_wdt.byt[i] = wdt.byt[lane];
      end
    end
  end

  //////////////////////////////////////////////////
  // request copies for the response cycle
  //////////////////////////////////////////////////

  logic [TCB_LOG-1:0] rsp_ofs;
  tcb_siz_t           rsp_siz;
  tcb_ndn_t           rsp_ndn;
  logic               rsp_mal;

  // response strobe, one cycle after each transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= xfer;
    end
  end

  // lane offset, size, byte order and error kept per transfer
  always_ff @(posedge clk) begin
    if (xfer) begin
      rsp_ofs <= req_ofs;
      rsp_siz <= siz;
      rsp_ndn <= ndn;
      rsp_mal <= req_mal;
    end
  end

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  // read data rotated back down to the low lanes
  always_comb begin
    logic [TCB_LOG-1:0] rsp_last;
    logic [TCB_LOG-1:0] src;
    rsp_last = siz_last(rsp_siz);
    for (int unsigned k = 0; k < TCB_BEN; k++) begin
      if (rsp_ndn == TCB_BIG) begin
        src = rsp_ofs + rsp_last - TCB_LOG'(k);
      end else begin
        src = rsp_ofs + TCB_LOG'(k);
      end
      rdt.byt[k] = mem_rdt.byt[src];
    end
  end

  // error only for misalignment
  assign sts = rsp_mal ? TCB_MISALIGNED : TCB_OKAY;

endmodule : tcb_riscv2memory

// File: logic/tcb_mem.sv
// TCB byte-enabled word memory
// clears every word after reset while holding off requests,
// then writes enabled lanes and returns read data one cycle later

module tcb_mem
  import tcb_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // request
  input  logic                         mem_vld,
  output logic                         mem_rdy,
  input  logic                         mem_wen,
  input  logic [$clog2(MEM_DEPTH)-1:0] mem_adr,
  input  logic [TCB_BEN-1:0]           mem_ben,
  input  tcb_data_t                    mem_wdt,
  // response
  output tcb_data_t                    mem_rdt
);

  localparam int unsigned AW = $clog2(MEM_DEPTH);

  // storage
  tcb_data_t mem [MEM_DEPTH];

  logic [AW-1:0] clr_cnt;
  logic          clr_done;
  logic          xfer;

  //////////////////////////////////////////////////
  // post-reset clear
  //////////////////////////////////////////////////

  // one word per cycle, MEM_DEPTH cycles in total
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_cnt  <= '0;
      clr_done <= 1'b0;
    end else if (!clr_done) begin
      if (clr_cnt == AW'(MEM_DEPTH - 1)) begin
        clr_done <= 1'b1;
      end
      // wraps back to zero on the last word
      clr_cnt <= clr_cnt + AW'(1);
    end
  end

  // ready only once the clear has finished
  assign mem_rdy = clr_done;
  assign xfer    = mem_vld & clr_done;

  //////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!clr_done) begin
      mem[clr_cnt] <= '0;
    end else if (xfer && mem_wen) begin
      // only enabled lanes change
      for (int unsigned i = 0; i < TCB_BEN; i++) begin
        if (mem_ben[i]) begin
          mem[mem_adr].byt[i] <= mem_wdt.byt[i];
        end
      end
    end
  end

  // addressed word, valid in the cycle after the transfer
  always_ff @(posedge clk) begin
    if (xfer) begin
      mem_rdt <= mem[mem_adr];
    end
  end

endmodule : tcb_mem

// File: logic/tcb_sys.sv
// TCB memory subsystem top level
// mode converter in front of the byte-enabled word memory,
// responses arrive one cycle after each transfer

module tcb_sys
  import tcb_pkg::*;
#(
  // memory size in words, a power of two
  parameter int unsigned MEM_DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // manager request
  input  logic                     vld,
  output logic                     rdy,
  input  logic                     wen,
  input  logic [TCB_ADR_WIDTH-1:0] adr,
  input  tcb_siz_t                 siz,
  input  tcb_ndn_t                 ndn,
  input  tcb_data_t                wdt,
  // manager response
  output logic                     rsp_vld,
  output tcb_data_t                rdt,
  output tcb_sts_t                 sts
);

  //////////////////////////////////////////////////
  // converter to memory wires
  //////////////////////////////////////////////////

  logic                         mem_vld;
  logic                         mem_rdy;
  logic                         mem_wen;
  logic [$clog2(MEM_DEPTH)-1:0] mem_adr;
  logic [TCB_BEN-1:0]           mem_ben;
  tcb_data_t                    mem_wdt;
  tcb_data_t                    mem_rdt;

  // stage 1, byte address to word and lanes
  tcb_riscv2memory #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_riscv2memory (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts),
    .mem_vld (mem_vld),
    .mem_rdy (mem_rdy),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  // stage 2, storage
  tcb_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_rdy (mem_rdy),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

endmodule : tcb_sys

// File: bench/tcb_sys_vectors.svh
// TCB memory subsystem test vectors
// one entry per transfer, applied in order by the testbench

// one request and the response it should produce
typedef struct packed {
  logic                     wen;
  logic [TCB_ADR_WIDTH-1:0] adr;
  tcb_siz_t                 siz;
  tcb_ndn_t                 ndn;
  logic [63:0]              wdt;
  logic [63:0]              exp_rdt;
  tcb_sts_t                 exp_sts;
} vec_t;

localparam int NUM_FIXED = 24;

// columns: wen, byte address, size, endianness, write data, expected rdt, expected sts
// rdt only counts for reads, and only within the access size
vec_t fixed_vecs [NUM_FIXED] = '{
  // cleared words read back as zero
  '{1'b0, 32'h0000_0000, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_0028, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_01f8, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0, TCB_OKAY},
  // aligned double round trip
  '{1'b1, 32'h0000_0040, TCB_DOUBLE, TCB_LITTLE, 64'h0123_4567_89ab_cdef, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_0040, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0123_4567_89ab_cdef, TCB_OKAY},
  // narrow writes into a known word, lanes 3, 6 and 7
  '{1'b1, 32'h0000_0080, TCB_DOUBLE, TCB_LITTLE, 64'h8877_6655_4433_2211, 64'h0, TCB_OKAY},
  '{1'b1, 32'h0000_0083, TCB_BYTE, TCB_LITTLE, 64'hdead_beef_dead_beaa, 64'h0, TCB_OKAY},
  '{1'b1, 32'h0000_0086, TCB_HALF, TCB_LITTLE, 64'h0000_0000_0000_ccbb, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_0080, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'hccbb_6655_aa33_2211, TCB_OKAY},
  // narrow reads land in the low lanes
  '{1'b0, 32'h0000_0085, TCB_BYTE, TCB_LITTLE, 64'h0, 64'h0000_0000_0000_0066, TCB_OKAY},
  '{1'b0, 32'h0000_0086, TCB_HALF, TCB_LITTLE, 64'h0, 64'h0000_0000_0000_ccbb, TCB_OKAY},
  '{1'b0, 32'h0000_0084, TCB_WORD, TCB_LITTLE, 64'h0, 64'h0000_0000_ccbb_6655, TCB_OKAY},
  // big endian, lowest address is the most significant byte
  '{1'b0, 32'h0000_0086, TCB_HALF, TCB_BIG, 64'h0, 64'h0000_0000_0000_bbcc, TCB_OKAY},
  '{1'b1, 32'h0000_00c0, TCB_WORD, TCB_BIG, 64'h0000_0000_1122_3344, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_00c0, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0000_0000_4433_2211, TCB_OKAY},
  '{1'b0, 32'h0000_00c0, TCB_WORD, TCB_BIG, 64'h0, 64'h0000_0000_1122_3344, TCB_OKAY},
  '{1'b0, 32'h0000_00c1, TCB_BYTE, TCB_BIG, 64'h0, 64'h0000_0000_0000_0022, TCB_OKAY},
  // misaligned, memory must stay as it was
  '{1'b1, 32'h0000_0101, TCB_HALF, TCB_LITTLE, 64'h0000_0000_0000_ffff, 64'h0, TCB_MISALIGNED},
  '{1'b1, 32'h0000_0102, TCB_WORD, TCB_LITTLE, 64'h0000_0000_ffff_ffff, 64'h0, TCB_MISALIGNED},
  '{1'b1, 32'h0000_0104, TCB_DOUBLE, TCB_LITTLE, 64'hffff_ffff_ffff_ffff, 64'h0, TCB_MISALIGNED},
  '{1'b0, 32'h0000_0085, TCB_WORD, TCB_LITTLE, 64'h0, 64'h0, TCB_MISALIGNED},
  '{1'b1, 32'h0000_0083, TCB_HALF, TCB_BIG, 64'h0000_0000_0000_ffff, 64'h0, TCB_MISALIGNED},
  '{1'b0, 32'h0000_0100, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'h0, TCB_OKAY},
  '{1'b0, 32'h0000_0080, TCB_DOUBLE, TCB_LITTLE, 64'h0, 64'hccbb_6655_aa33_2211, TCB_OKAY}
};

// File: bench/tcb_sys_tb.sv
// TCB memory subsystem testbench
// streams a table of requests through the DUT after the clear phase
// and checks every response, its timing and its order

module tcb_sys_tb
  import tcb_pkg::*;
;

  localparam int MEM_DEPTH = 64;
  localparam int NUM_RAND  = 3;

  `include "tcb_sys_vectors.svh"

  localparam int NUM_VECS    = NUM_FIXED + 2 * NUM_RAND;
  localparam int CYCLE_LIMIT = MEM_DEPTH + 4 * NUM_VECS + 20;

  logic                     clk;
  logic                     rst_n;
  logic                     vld;
  logic                     rdy;
  logic                     wen;
  logic [TCB_ADR_WIDTH-1:0] adr;
  tcb_siz_t                 siz;
  tcb_ndn_t                 ndn;
  tcb_data_t                wdt;
  logic                     rsp_vld;
  tcb_data_t                rdt;
  tcb_sts_t                 sts;

  vec_t vecs [$];
  int   seed;
  int   rsp_cnt   = 0;
  int   cycles    = 0;
  int   data_errs = 0;
  int   sts_errs  = 0;
  int   flag_errs = 0;
  // transfer seen at the previous falling edge
  logic pend      = 1'b0;

  tcb_sys #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_tcb_sys (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // compare helpers
  //////////////////////////////////////////////////

  // bytes that carry data for a given size
  function automatic logic [63:0] valid_bytes_mask(input tcb_siz_t s);
    case (s)
      TCB_BYTE: valid_bytes_mask = 64'h0000_0000_0000_00ff;
      TCB_HALF: valid_bytes_mask = 64'h0000_0000_0000_ffff;
      TCB_WORD: valid_bytes_mask = 64'h0000_0000_ffff_ffff;
      default:  valid_bytes_mask = 64'hffff_ffff_ffff_ffff;
    endcase
  endfunction

  task automatic check_data(input string name, input int idx, input tcb_data_t exp,
                            input tcb_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("FAILED %s entry %0d: expected %h, got %h", name, idx, exp.wrd, act.wrd);
    end
  endtask

  task automatic check_sts(input string name, input int idx, input tcb_sts_t exp,
                           input tcb_sts_t act);
    if (act !== exp) begin
      sts_errs++;
      $display("FAILED %s entry %0d: expected %h, got %h", name, idx, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // response monitor, falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    vec_t v;
    // exactly one response one cycle after each transfer
    check_flag("rsp_vld", pend, rsp_vld);
    if (rsp_vld === 1'b1 && rsp_cnt < NUM_VECS) begin
      v = vecs[rsp_cnt];
      check_sts("sts", rsp_cnt, v.exp_sts, sts);
      // read data only counts on good reads within the size
      if (!v.wen && v.exp_sts == TCB_OKAY) begin
        check_data("rdt", rsp_cnt, v.exp_rdt, rdt.wrd & valid_bytes_mask(v.siz));
      end
      rsp_cnt++;
    end
    pend = vld && rdy;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, responses never arrived (%0d of %0d)",
               cycles, rsp_cnt, NUM_VECS);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    vec_t        v;
    logic [63:0] rnd;
    seed  = 4;
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = TCB_BYTE;
    ndn   = TCB_LITTLE;
    wdt   = '0;
    for (int i = 0; i < NUM_FIXED; i++) begin
      vecs.push_back(fixed_vecs[i]);
    end
    // random doubles written then read back in the upper quarter of memory
    for (int r = 0; r < NUM_RAND; r++) begin
      rnd = {$random(seed), $random(seed)};
      vecs.push_back('{1'b1, 32'h180 + 32'(8 * r), TCB_DOUBLE, TCB_LITTLE, rnd, 64'h0,
                       TCB_OKAY});
      vecs.push_back('{1'b0, 32'h180 + 32'(8 * r), TCB_DOUBLE, TCB_LITTLE, 64'h0, rnd,
                       TCB_OKAY});
    end

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // memory still clearing
    @(negedge clk);
    check_flag("rdy", 1'b0, rdy);

    // one entry per transfer held while rdy is low
    for (int i = 0; i < NUM_VECS; i++) begin
      v = vecs[i];
      @(posedge clk);
      vld     <= 1'b1;
      wen     <= v.wen;
      adr     <= v.adr;
      siz     <= v.siz;
      ndn     <= v.ndn;
      wdt.wrd <= v.wdt;
      @(negedge clk);
      // no back-pressure once the clear is over
      if (i > 0) begin
        check_flag("rdy", 1'b1, rdy);
      end
      while (!rdy) @(negedge clk);
    end
    @(posedge clk);
    vld <= 1'b0;

    while (rsp_cnt < NUM_VECS) @(posedge clk);
    // one more cycle to catch a stray response
    @(negedge clk);
    @(posedge clk);
    $display("errors: data %0d, status %0d, handshake %0d", data_errs, sts_errs, flag_errs);
    if (data_errs + sts_errs + flag_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tcb_sys_tb

// File: tcb_sys.f
+incdir+bench
logic/tcb_pkg.sv
logic/tcb_riscv2memory.sv
logic/tcb_mem.sv
logic/tcb_sys.sv
bench/tcb_sys_tb.sv

// File: Makefile
# Verilator build and run for the TCB memory subsystem

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tcb_sys_tb
FILELIST  = tcb_sys.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test passed

SOURCES = $(wildcard logic/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
